// ==== hw/fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// instruction buffer size in words
`define IMEM_DEPTH      512

// program counter indexes the buffer directly, one word per step
`define PC_WIDTH        9

`define INSTR_WIDTH     32

// slots fetched and predecoded per cycle
`define ISSUE_WIDTH     2

`define REG_ADDR_WIDTH  5

`endif

// ==== hw/isa_pkg.sv ====
`include "fetch_settings.svh"

package isa_pkg;

    typedef enum logic [5:0] {
        OP_NOP    = 6'd0,
        OP_ALU_R,
        OP_ALU_I,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH
    } opcode_e;

    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    typedef struct packed {
        opcode_e   opcode;  // 31:26
        reg_addr_t rd;      // 25:21
        reg_addr_t rs1;     // 20:16
        reg_addr_t rs2;     // 15:11
        logic [10:0] funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        logic [15:0] imm;   // also the branch target
    } i_fmt_t;

    // opcode decides which view holds
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_word_u;

    // r0 writes are dropped, so they never create a dependency
    function automatic logic writes_rd(instr_word_u w);
        case (w.r.opcode)
            OP_ALU_R, OP_ALU_I, OP_LOAD: return (w.r.rd != '0);
            default:                     return 1'b0;
        endcase
    endfunction

    function automatic logic reads_src1(instr_word_u w);
        case (w.r.opcode)
            OP_ALU_R, OP_ALU_I, OP_LOAD, OP_STORE, OP_BRANCH: return 1'b1;
            default:                                         return 1'b0;
        endcase
    endfunction

    function automatic logic reads_src2(instr_word_u w);
        case (w.r.opcode)
            OP_ALU_R, OP_STORE, OP_BRANCH: return 1'b1;
            default:                       return 1'b0;
        endcase
    endfunction

    // store data and branch compare operand sit in the rd field
    function automatic reg_addr_t src2_of(instr_word_u w);
        if (w.r.opcode == OP_ALU_R) begin
            return w.r.rs2;
        end
        return w.i.rd;
    endfunction

endpackage

// ==== hw/fetch_pkg.sv ====
`include "fetch_settings.svh"

package fetch_pkg;

    // one step per word, pairs start on even values
    typedef logic [`PC_WIDTH-1:0] pc_t;

    // raw word as held in the buffer
    typedef logic [`INSTR_WIDTH-1:0] instr_t;

    // coarse unit class, enough for pairing rules
    typedef enum logic [2:0] {
        CLASS_NONE   = 3'd0,
        CLASS_ALU    = 3'd1,
        CLASS_MEM    = 3'd2,
        CLASS_BRANCH = 3'd3
    } instr_class_e;

endpackage

// ==== hw/instr_fetch.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

module instr_fetch
    import fetch_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load_en,
    input  pc_t                       load_addr,
    input  instr_t                    load_data,
    input  logic                      redirect,
    input  pc_t                       redirect_target,
    input  logic                      stall,
    input  logic                      hold,
    output instr_t [`ISSUE_WIDTH-1:0] slot_instr,
    output pc_t    [`ISSUE_WIDTH-1:0] slot_pc,
    output logic   [`ISSUE_WIDTH-1:0] slot_valid,
    output logic                      end_of_program
);

    instr_t imem [`IMEM_DEPTH];

    pc_t  pc;
    pc_t  fetch_base;   // aligned address of the pair read this cycle
    logic advance;
    logic odd_target;

    // redirect wins over stall and hold
    assign advance = redirect | ~(stall | hold);

    // odd target drops the word below it from slot 0
    assign odd_target = redirect & redirect_target[0];

    assign fetch_base = redirect ? {redirect_target[`PC_WIDTH-1:1], 1'b0} : pc;

    // write port, used while the pipe is frozen
    always_ff @(posedge clk) begin
        if (load_en) begin
            imem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc         <= '0;
            slot_valid <= '0;
        end else if (advance) begin
            pc         <= fetch_base + pc_t'(`ISSUE_WIDTH);
            slot_valid <= {{(`ISSUE_WIDTH-1){1'b1}}, ~odd_target};
        end
    end

    // pair read, slot pc comes along so lanes stay index free
    always_ff @(posedge clk) begin
        if (advance) begin
            for (int s = 0; s < `ISSUE_WIDTH; s++) begin
                slot_instr[s] <= imem[fetch_base + pc_t'(s)];
                slot_pc[s]    <= fetch_base + pc_t'(s);
            end
        end
    end

    // sticky once the last pair has been addressed
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            end_of_program <= 1'b0;
        end else if (redirect) begin
            end_of_program <= 1'b0;
        end else if (pc == pc_t'(`IMEM_DEPTH - 2)) begin
            end_of_program <= 1'b1;
        end
    end

endmodule

// ==== hw/slot_predecode.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

module slot_predecode
    import isa_pkg::*;
    import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         redirect,
    input  logic         stall,
    input  logic         hold,
    input  logic         in_valid,
    input  instr_word_u  in_instr,
    input  pc_t          in_pc,
    output logic         out_valid,
    output instr_word_u  out_instr,
    output pc_t          out_pc,
    output reg_addr_t    dest,
    output logic         dest_we,
    output reg_addr_t    src1,
    output reg_addr_t    src2,
    output logic         src1_re,
    output logic         src2_re,
    output instr_class_e iclass
);

    logic advance;

    assign advance = ~(stall | hold);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (redirect) begin
            out_valid <= 1'b0;  // wrong path
        end else if (advance) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_instr <= in_instr;
            out_pc    <= in_pc;
        end
    end

    // register use, decoded from the held word
    assign dest    = out_instr.i.rd;
    assign dest_we = writes_rd(out_instr);
    assign src1    = out_instr.i.rs1;
    assign src1_re = reads_src1(out_instr);
    assign src2    = src2_of(out_instr);
    assign src2_re = reads_src2(out_instr);

    always_comb begin
        case (out_instr.r.opcode)
            OP_ALU_R, OP_ALU_I: iclass = CLASS_ALU;
            OP_LOAD, OP_STORE:  iclass = CLASS_MEM;
            OP_BRANCH:          iclass = CLASS_BRANCH;
            default:            iclass = CLASS_NONE;   // nop and unknown opcodes
        endcase
    end

endmodule

// ==== hw/pair_dispatch.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

module pair_dispatch
    import isa_pkg::*;
    import fetch_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            redirect,
    input  logic                            stall,
    input  logic         [`ISSUE_WIDTH-1:0] lane_valid,
    input  instr_word_u  [`ISSUE_WIDTH-1:0] lane_instr,
    input  pc_t          [`ISSUE_WIDTH-1:0] lane_pc,
    input  reg_addr_t    [`ISSUE_WIDTH-1:0] lane_dest,
    input  logic         [`ISSUE_WIDTH-1:0] lane_dest_we,
    input  reg_addr_t    [`ISSUE_WIDTH-1:0] lane_src1,
    input  reg_addr_t    [`ISSUE_WIDTH-1:0] lane_src2,
    input  logic         [`ISSUE_WIDTH-1:0] lane_src1_re,
    input  logic         [`ISSUE_WIDTH-1:0] lane_src2_re,
    input  instr_class_e [`ISSUE_WIDTH-1:0] lane_iclass,
    output logic                            hold,
    output logic                            issue0_valid,
    output logic         [`INSTR_WIDTH-1:0] issue0_instr,
    output pc_t                             issue0_pc,
    output logic                            issue1_valid,
    output logic         [`INSTR_WIDTH-1:0] issue1_instr,
    output pc_t                             issue1_pc
);

    logic        raw_hit;
    logic        two_branch;
    logic        split;
    logic        phase;       // second half of a split pair
    logic        issue0_q;
    logic        issue1_q;
    instr_word_u kept_instr;  // slot 1 parked during a split
    pc_t         kept_pc;

    // slot 1 source against slot 0 destination
    assign raw_hit = lane_dest_we[0] &
                     ((lane_src1_re[1] & (lane_src1[1] == lane_dest[0])) |
                      (lane_src2_re[1] & (lane_src2[1] == lane_dest[0])));

    // at most one branch per issue cycle
    assign two_branch = (lane_iclass[0] == CLASS_BRANCH) &
                        (lane_iclass[1] == CLASS_BRANCH);

    assign split = lane_valid[0] & lane_valid[1] & (raw_hit | two_branch);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase    <= 1'b0;
            issue0_q <= 1'b0;
            issue1_q <= 1'b0;
        end else if (redirect) begin
            phase    <= 1'b0;
            issue0_q <= 1'b0;
            issue1_q <= 1'b0;
        end else if (!stall) begin
            if (phase) begin
                // parked slot 1 goes out alone, lanes were frozen
                phase    <= 1'b0;
                issue0_q <= 1'b0;
                issue1_q <= 1'b1;
            end else begin
                phase    <= split;
                issue0_q <= lane_valid[0];
                issue1_q <= lane_valid[1] & ~split;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (phase) begin
                issue1_instr <= kept_instr;
                issue1_pc    <= kept_pc;
            end else begin
                issue0_instr <= lane_instr[0];
                issue0_pc    <= lane_pc[0];
                issue1_instr <= lane_instr[1];
                issue1_pc    <= lane_pc[1];
                kept_instr   <= lane_instr[1];
                kept_pc      <= lane_pc[1];
            end
        end
    end

    // freeze fetch and lanes while the parked slot drains
    assign hold = phase;

    // nothing counts as issued during a stall or in the redirect cycle
    assign issue0_valid = issue0_q & ~stall & ~redirect;
    assign issue1_valid = issue1_q & ~stall & ~redirect;

endmodule

// ==== hw/fetch_top.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_top
    import isa_pkg::*;
    import fetch_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load_en,
    input  pc_t                      load_addr,
    input  logic [`INSTR_WIDTH-1:0]  load_data,
    input  logic                     redirect,
    input  pc_t                      redirect_target,
    input  logic                     stall,
    output logic                     issue0_valid,
    output logic [`INSTR_WIDTH-1:0]  issue0_instr,
    output pc_t                      issue0_pc,
    output logic                     issue1_valid,
    output logic [`INSTR_WIDTH-1:0]  issue1_instr,
    output pc_t                      issue1_pc,
    output logic                     end_of_program
);

    // fetch to lanes
    instr_t       [`ISSUE_WIDTH-1:0] slot_instr;
    pc_t          [`ISSUE_WIDTH-1:0] slot_pc;
    logic         [`ISSUE_WIDTH-1:0] slot_valid;

    // lanes to dispatcher
    logic         [`ISSUE_WIDTH-1:0] lane_valid;
    instr_word_u  [`ISSUE_WIDTH-1:0] lane_instr;
    pc_t          [`ISSUE_WIDTH-1:0] lane_pc;
    reg_addr_t    [`ISSUE_WIDTH-1:0] lane_dest;
    logic         [`ISSUE_WIDTH-1:0] lane_dest_we;
    reg_addr_t    [`ISSUE_WIDTH-1:0] lane_src1;
    reg_addr_t    [`ISSUE_WIDTH-1:0] lane_src2;
    logic         [`ISSUE_WIDTH-1:0] lane_src1_re;
    logic         [`ISSUE_WIDTH-1:0] lane_src2_re;
    instr_class_e [`ISSUE_WIDTH-1:0] lane_iclass;

    logic hold;     // dispatcher split in progress

    instr_fetch u_fetch (
        .clk             (clk),
        .rst             (rst),
        .load_en         (load_en),
        .load_addr       (load_addr),
        .load_data       (load_data),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .stall           (stall),
        .hold            (hold),
        .slot_instr      (slot_instr),
        .slot_pc         (slot_pc),
        .slot_valid      (slot_valid),
        .end_of_program  (end_of_program)
    );

    for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : g_lane
        slot_predecode u_lane (
            .clk       (clk),
            .rst       (rst),
            .redirect  (redirect),
            .stall     (stall),
            .hold      (hold),
            .in_valid  (slot_valid[i]),
            .in_instr  (slot_instr[i]),
            .in_pc     (slot_pc[i]),
            .out_valid (lane_valid[i]),
            .out_instr (lane_instr[i]),
            .out_pc    (lane_pc[i]),
            .dest      (lane_dest[i]),
            .dest_we   (lane_dest_we[i]),
            .src1      (lane_src1[i]),
            .src2      (lane_src2[i]),
            .src1_re   (lane_src1_re[i]),
            .src2_re   (lane_src2_re[i]),
            .iclass    (lane_iclass[i])
        );
    end

    pair_dispatch u_dispatch (
        .clk          (clk),
        .rst          (rst),
        .redirect     (redirect),
        .stall        (stall),
        .lane_valid   (lane_valid),
        .lane_instr   (lane_instr),
        .lane_pc      (lane_pc),
        .lane_dest    (lane_dest),
        .lane_dest_we (lane_dest_we),
        .lane_src1    (lane_src1),
        .lane_src2    (lane_src2),
        .lane_src1_re (lane_src1_re),
        .lane_src2_re (lane_src2_re),
        .lane_iclass  (lane_iclass),
        .hold         (hold),
        .issue0_valid (issue0_valid),
        .issue0_instr (issue0_instr),
        .issue0_pc    (issue0_pc),
        .issue1_valid (issue1_valid),
        .issue1_instr (issue1_instr),
        .issue1_pc    (issue1_pc)
    );

endmodule

// ==== sim/tb_fetch_top.sv ====
`timescale 1ns/1ps
`include "fetch_settings.svh"

module tb_fetch_top
    import isa_pkg::*;
();

    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 8;
    localparam int DEPTH        = `IMEM_DEPTH;
    localparam logic [31:0] LCG_SEED = 32'h0b9f_217e;

    typedef logic [`PC_WIDTH-1:0] addr_t;

    typedef struct packed {
        addr_t       pc;
        logic [31:0] instr;
        logic        port;
        logic        paired;  // other port issues in the same cycle
        logic [1:0]  eop;     // 0 low, 1 high, 2 not checked
    } issue_item_t;

    typedef struct packed {
        addr_t       addr;
        logic [31:0] word;
    } prog_entry_t;

    logic        clk;
    logic        rst;
    logic        load_en;
    addr_t       load_addr;
    logic [31:0] load_data;
    logic        redirect = 1'b0;
    addr_t       redirect_target = '0;
    logic        stall = 1'b1;   // frozen until the image is loaded

    logic        issue0_valid;
    logic [31:0] issue0_instr;
    addr_t       issue0_pc;
    logic        issue1_valid;
    logic [31:0] issue1_instr;
    addr_t       issue1_pc;
    logic        end_of_program;

    logic [31:0] image [DEPTH];
    prog_entry_t prog_table [$];
    issue_item_t expected [$];
    int          exp_idx = 0;
    int          n_exp = 0;
    int          cycle_count = 0;
    int          timeout_limit = 1000000;
    logic        running = 1'b0;
    logic        redirect_req = 1'b0;
    addr_t       redirect_req_target = '0;
    logic [31:0] lcg_state = LCG_SEED;
    int          stall_left = 0;

    fetch_top u_dut (
        .clk             (clk),
        .rst             (rst),
        .load_en         (load_en),
        .load_addr       (load_addr),
        .load_data       (load_data),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .stall           (stall),
        .issue0_valid    (issue0_valid),
        .issue0_instr    (issue0_instr),
        .issue0_pc       (issue0_pc),
        .issue1_valid    (issue1_valid),
        .issue1_instr    (issue1_instr),
        .issue1_pc       (issue1_pc),
        .end_of_program  (end_of_program)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] enc_r(opcode_e op, int rd, int rs1, int rs2);
        instr_word_u w;
        w.r.opcode = op;
        w.r.rd     = reg_addr_t'(rd);
        w.r.rs1    = reg_addr_t'(rs1);
        w.r.rs2    = reg_addr_t'(rs2);
        w.r.funct  = '0;
        return w;
    endfunction

    function automatic logic [31:0] enc_i(opcode_e op, int rd, int rs1, int imm);
        instr_word_u w;
        w.i.opcode = op;
        w.i.rd     = reg_addr_t'(rd);
        w.i.rs1    = reg_addr_t'(rs1);
        w.i.imm    = 16'(imm);
        return w;
    endfunction

    // register reads by opcode with r0 ignored
    function automatic logic reads_reg(logic [31:0] w, reg_addr_t r);
        instr_word_u u;
        logic        hit;
        u = w;
        case (u.r.opcode)
            OP_ALU_R:            hit = (u.r.rs1 == r) || (u.r.rs2 == r);
            OP_ALU_I, OP_LOAD:   hit = (u.r.rs1 == r);
            OP_STORE, OP_BRANCH: hit = (u.r.rs1 == r) || (u.r.rd == r);
            default:             hit = 1'b0;
        endcase
        return hit && (r != '0);
    endfunction

    function automatic logic writes_reg(logic [31:0] w);
        instr_word_u u;
        u = w;
        return (u.r.opcode inside {OP_ALU_R, OP_ALU_I, OP_LOAD}) && (u.r.rd != '0);
    endfunction

    function automatic logic is_branch(logic [31:0] w);
        instr_word_u u;
        u = w;
        return u.r.opcode == OP_BRANCH;
    endfunction

    function automatic addr_t branch_target(logic [31:0] w);
        instr_word_u u;
        u = w;
        return u.i.imm[`PC_WIDTH-1:0];
    endfunction

    function automatic logic must_split(logic [31:0] w0, logic [31:0] w1);
        instr_word_u u0;
        u0 = w0;
        return (writes_reg(w0) && reads_reg(w1, u0.r.rd)) || (is_branch(w0) && is_branch(w1));
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic build_image();
        // nop fill carries its own address in the immediate
        for (int a = 0; a < DEPTH; a++) begin
            image[a] = enc_i(OP_NOP, 0, 0, a);
        end
        prog_table.push_back('{9'd0,   enc_i(OP_ALU_I, 1, 0, 5)});
        prog_table.push_back('{9'd1,   enc_r(OP_ALU_R, 2, 3, 4)});
        prog_table.push_back('{9'd2,   enc_i(OP_ALU_I, 5, 1, 7)});
        prog_table.push_back('{9'd3,   enc_r(OP_ALU_R, 6, 5, 7)});   // reads r5
        prog_table.push_back('{9'd4,   enc_i(OP_ALU_I, 0, 2, 1)});   // writes r0
        prog_table.push_back('{9'd5,   enc_r(OP_ALU_R, 8, 0, 0)});
        prog_table.push_back('{9'd6,   enc_i(OP_LOAD, 9, 1, 4)});
        prog_table.push_back('{9'd7,   enc_i(OP_STORE, 9, 2, 8)});   // store data r9
        prog_table.push_back('{9'd8,   enc_i(OP_BRANCH, 2, 1, 20)});
        prog_table.push_back('{9'd9,   enc_i(OP_ALU_I, 10, 3, 1)});
        prog_table.push_back('{9'd20,  enc_i(OP_ALU_I, 11, 4, 2)});
        prog_table.push_back('{9'd21,  enc_i(OP_BRANCH, 2, 1, 33)}); // odd target
        prog_table.push_back('{9'd33,  enc_i(OP_ALU_I, 12, 1, 3)});
        prog_table.push_back('{9'd34,  enc_r(OP_ALU_R, 13, 12, 1)});
        prog_table.push_back('{9'd35,  enc_i(OP_ALU_I, 14, 13, 0)});
        prog_table.push_back('{9'd510, enc_i(OP_BRANCH, 3, 4, 40)});
        prog_table.push_back('{9'd511, enc_i(OP_ALU_I, 15, 6, 9)});
        foreach (prog_table[k]) begin
            image[prog_table[k].addr] = prog_table[k].word;
        end
    endtask

    task automatic add_expected(input logic [31:0] w, input addr_t pc, input logic port,
                                input logic paired, input logic wrapped);
        issue_item_t item;
        item.pc     = pc;
        item.instr  = w;
        item.port   = port;
        item.paired = paired;
        if (wrapped) begin
            item.eop = 2'd0;
        end else if (pc >= addr_t'(DEPTH - 6)) begin
            item.eop = 2'd1;
        end else if (pc < addr_t'(DEPTH - 8)) begin
            item.eop = 2'd0;
        end else begin
            item.eop = 2'd2;   // flag edge depends on stalls
        end
        expected.push_back(item);
    endtask

    // walk the program in issue order with the slot index as port
    task automatic build_expected();
        addr_t       base;
        addr_t       tgt;
        logic        odd_entry;
        logic        wrapped;
        logic        take;
        logic        split;
        logic [31:0] w0;
        logic [31:0] w1;
        int          guard;
        base = '0;
        odd_entry = 1'b0;
        wrapped = 1'b0;
        guard = 0;
        while (!(wrapped && base >= 9'd44) && guard < 2000) begin
            guard++;
            take = 1'b0;
            tgt = '0;
            w0 = image[base];
            w1 = image[base + 9'd1];
            split = must_split(w0, w1);   // each half then issues alone
            if (odd_entry) begin
                add_expected(w1, base + 9'd1, 1'b1, 1'b0, wrapped);
                if (is_branch(w1)) begin
                    take = 1'b1;
                    tgt = branch_target(w1);
                end
            end else begin
                add_expected(w0, base, 1'b0, !split, wrapped);
                if (is_branch(w0)) begin
                    take = 1'b1;
                    tgt = branch_target(w0);
                    if (!split) begin
                        add_expected(w1, base + 9'd1, 1'b1, 1'b1, wrapped);
                    end
                end else begin
                    add_expected(w1, base + 9'd1, 1'b1, !split, wrapped);
                    if (is_branch(w1)) begin
                        take = 1'b1;
                        tgt = branch_target(w1);
                    end
                end
            end
            if (take) begin
                if (base == addr_t'(DEPTH - 2)) begin
                    wrapped = 1'b1;
                end
                base = {tgt[`PC_WIDTH-1:1], 1'b0};
                odd_entry = tgt[0];
            end else begin
                base = base + 9'd2;
                odd_entry = 1'b0;
            end
        end
        n_exp = expected.size();
    endtask

    task automatic take_issue(input logic port, input logic [31:0] instr, input addr_t pc,
                              input logic other_valid);
        issue_item_t item;
        if (exp_idx >= n_exp) begin
            stop_with_failure($sformatf("unexpected issue past the end of the program, pc 0x%h", pc));
        end else begin
            item = expected[exp_idx];
            check_value("issue port", 32'(port), 32'(item.port));
            check_value(port ? "issue0_valid" : "issue1_valid", 32'(other_valid),
                        32'(item.paired));
            check_value(port ? "issue1_instr" : "issue0_instr", instr, item.instr);
            check_value(port ? "issue1_pc" : "issue0_pc", 32'(pc), 32'(item.pc));
            if (item.eop != 2'd2) begin
                check_value("end_of_program", 32'(end_of_program), 32'(item.eop[0]));
            end
            exp_idx = exp_idx + 1;
            if (is_branch(instr)) begin
                redirect_req = 1'b1;   // branches are always taken
                redirect_req_target = branch_target(instr);
            end
        end
    endtask

    // outputs settle long before the falling edge
    always @(negedge clk) begin
        redirect_req = 1'b0;
        if (running) begin
            if (stall) begin
                check_value("issue0_valid", 32'(issue0_valid), 32'h0);
                check_value("issue1_valid", 32'(issue1_valid), 32'h0);
            end else begin
                if (issue0_valid) begin
                    take_issue(1'b0, issue0_instr, issue0_pc, issue1_valid);
                end
                if (issue1_valid) begin
                    take_issue(1'b1, issue1_instr, issue1_pc, issue0_valid);
                end
            end
        end
    end

    // redirect one edge after a branch issue and LCG stall windows
    always @(posedge clk) begin
        if (!running) begin
            stall    <= 1'b1;
            redirect <= 1'b0;
        end else begin
            redirect        <= redirect_req;
            redirect_target <= redirect_req_target;
            if (stall_left > 0) begin
                stall      <= 1'b1;
                stall_left <= stall_left - 1;
            end else begin
                lcg_state = lcg_next(lcg_state);
                if (lcg_state[31:28] == 4'h0) begin
                    stall      <= 1'b1;
                    stall_left <= int'(lcg_state[2:0]);
                end else begin
                    stall <= 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            stop_with_failure($sformatf("timeout after %0d cycles, %0d of %0d issues seen",
                                        cycle_count, exp_idx, n_exp));
        end
    end

    initial begin
        rst       <= 1'b1;
        load_en   <= 1'b0;
        load_addr <= '0;
        load_data <= '0;
        build_image();
        build_expected();
        timeout_limit = 8 * n_exp + DEPTH + 100;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int a = 0; a < DEPTH; a++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= addr_t'(a);
            load_data <= image[a];
        end
        @(posedge clk);
        load_en <= 1'b0;
        running <= 1'b1;
        wait (exp_idx == n_exp);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+hw
hw/isa_pkg.sv
hw/fetch_pkg.sv
hw/instr_fetch.sv
hw/slot_predecode.sv
hw/pair_dispatch.sv
hw/fetch_top.sv
sim/tb_fetch_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_fetch_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
